// File: src/rxbuf_settings.svh
////////////////////
// widths, tag count, tag base and completion header codes
////////////////////
`ifndef RXBUF_SETTINGS_SVH
`define RXBUF_SETTINGS_SVH

// ring size in quadwords is 2**RXBUF_AW
`define RXBUF_AW 9

// up to 2**RXBUF_TAGW outstanding reads
`define RXBUF_TAGW 2

`define RXBUF_TAG_BASE 5'b10100     // upper bits must match on completions

// completion with data, fmt 2'b10 type 5'b01010
`define RXBUF_CPL_FMT_TYPE 7'b1001010
`define RXBUF_CPL_SC 3'b000         // successful completion

`endif

// File: src/rxbuf_pkg.sv
////////////////////
// shared vector types, stream and request structs, fsm states
////////////////////
`include "rxbuf_settings.svh"

package rxbuf_pkg;

    typedef logic [63:0]            qw_t;
    typedef logic [63:0]            host_addr_t;
    typedef logic [`RXBUF_AW:0]     buf_ptr_t;      // msb is the wrap bit
    typedef logic [`RXBUF_AW-1:0]   buf_addr_t;
    typedef logic [31:0]            qw_len_t;
    typedef logic [`RXBUF_TAGW-1:0] tag_t;

    typedef struct packed {
        qw_t  data;
        logic sof;
        logic eof;
        logic valid;
    } trn_rx_t;

    typedef struct packed {
        host_addr_t addr;
        logic [9:0] qw;
        tag_t       tag;
    } rd_req_t;

    typedef struct packed {
        tag_t       tag;
        buf_ptr_t   base;       // ring slot reserved for the request
        logic [9:0] qw;
    } alloc_t;

    typedef struct packed {
        logic valid;
        qw_t  data;
        tag_t tag;
        logic last;
    } cpl_beat_t;

    typedef enum logic [2:0] {
        RD_IDLE,
        RD_CHUNK,
        RD_CHECK,
        RD_REQ,
        RD_ACK_LOW,
        RD_DONE
    } rd_state_t;

    typedef enum logic {
        CM_WAIT,
        CM_RETIRE
    } commit_state_t;

endpackage

// File: src/rd_req_gen.sv
////////////////////
// descriptor chunking and read request issue
////////////////////
`include "rxbuf_settings.svh"

module rd_req_gen (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  lbuf_req,
    input  rxbuf_pkg::host_addr_t lbuf_addr,
    input  rxbuf_pkg::qw_len_t    lbuf_qw,
    output logic                  lbuf_ack,
    input  logic [2:0]            cfg_max_rd_req_size,
    input  rxbuf_pkg::buf_ptr_t   committed_cons,
    input  logic                  retire,
    output logic                  rd_req,
    output rxbuf_pkg::rd_req_t    rd,
    input  logic                  rd_ack,
    output logic                  alloc_en,
    output rxbuf_pkg::alloc_t     alloc
);
    import rxbuf_pkg::*;

    localparam logic [`RXBUF_AW+1:0] RING_QW = {2'b01, {`RXBUF_AW{1'b0}}};

    rd_state_t            state;
    qw_len_t              qw_left;
    host_addr_t           next_addr;
    buf_ptr_t             iprod;        // issued producer pointer
    tag_t                 next_tag;
    logic [`RXBUF_TAGW:0] os_cnt;       // outstanding requests
    logic [9:0]           mx_qw;
    logic [9:0]           chunk_qw;
    buf_ptr_t             used;
    logic [`RXBUF_AW+1:0] need;
    logic                 space_ok;

    always_comb begin
        case (cfg_max_rd_req_size)
            3'd0:    mx_qw = 10'd16;
            3'd1:    mx_qw = 10'd32;
            3'd2:    mx_qw = 10'd64;
            default: mx_qw = 10'd128;
        endcase
    end

    assign chunk_qw = (qw_left < qw_len_t'(mx_qw)) ? qw_left[9:0] : mx_qw;

    // ring occupancy if the pending chunk were issued
    assign used     = iprod - committed_cons;
    assign need     = {1'b0, used} + {1'b0, rd.qw};
    assign space_ok = (need <= RING_QW);

    ////////////////////
    // request fsm
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= RD_IDLE;
            lbuf_ack <= 1'b0;
            rd_req   <= 1'b0;
            alloc_en <= 1'b0;
            iprod    <= '0;
            next_tag <= '0;
        end else begin
            alloc_en <= 1'b0;
            case (state)
                RD_IDLE: begin
                    if (lbuf_req) begin
                        next_addr <= lbuf_addr;
                        qw_left   <= lbuf_qw;
                        state     <= RD_CHUNK;
                    end
                end
                RD_CHUNK: begin
                    if (qw_left == '0) begin
                        lbuf_ack <= 1'b1;   // whole descriptor issued
                        state    <= RD_DONE;
                    end else begin
                        rd.addr <= next_addr;
                        rd.qw   <= chunk_qw;
                        rd.tag  <= next_tag;
                        state   <= RD_CHECK;
                    end
                end
                RD_CHECK: begin
                    // hold off on a full tag set or a full ring
                    if (!os_cnt[`RXBUF_TAGW] && space_ok && !rd_ack) begin
                        rd_req <= 1'b1;
                        state  <= RD_REQ;
                    end
                end
                RD_REQ: begin
                    if (rd_ack) begin
                        rd_req     <= 1'b0;
                        alloc_en   <= 1'b1;
                        alloc.tag  <= rd.tag;
                        alloc.base <= iprod;
                        alloc.qw   <= rd.qw;
                        iprod      <= iprod + rd.qw;
                        next_addr  <= next_addr + host_addr_t'({rd.qw, 3'b000});
                        qw_left    <= qw_left - qw_len_t'(rd.qw);
                        next_tag   <= next_tag + tag_t'(1);
                        state      <= RD_ACK_LOW;
                    end
                end
                RD_ACK_LOW: begin
                    if (!rd_ack) begin
                        state <= RD_CHUNK;
                    end
                end
                RD_DONE: begin
                    if (!lbuf_req) begin
                        lbuf_ack <= 1'b0;
                        state    <= RD_IDLE;
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            os_cnt <= '0;
        end else if (alloc_en && !retire) begin
            os_cnt <= os_cnt + 1'b1;
        end else if (!alloc_en && retire) begin
            os_cnt <= os_cnt - 1'b1;
        end
    end

endmodule

// File: src/cpl_parser.sv
////////////////////
// completion header decode and filter
////////////////////
`include "rxbuf_settings.svh"

module cpl_parser (
    input  logic                 clk,
    input  logic                 rst,
    input  rxbuf_pkg::trn_rx_t   trn,
    output rxbuf_pkg::cpl_beat_t beat
);
    import rxbuf_pkg::*;

    localparam logic [4:0] TAG_BASE = `RXBUF_TAG_BASE;

    logic       tag_phase;  // next beat carries the tag
    logic       hdr_ok;
    logic       accept;     // payload beats pass until eof
    tag_t       cur_tag;
    logic [9:0] dw_len;
    logic       fmt_ok;

    assign dw_len = trn.data[41:32];
    assign fmt_ok = (trn.data[62:56] == `RXBUF_CPL_FMT_TYPE) &&
                    (trn.data[15:13] == `RXBUF_CPL_SC) &&
                    (dw_len != '0) && !dw_len[0];   // qw aligned only

    always_ff @(posedge clk) begin
        if (rst) begin
            tag_phase  <= 1'b0;
            hdr_ok     <= 1'b0;
            accept     <= 1'b0;
            beat.valid <= 1'b0;
        end else begin
            beat.valid <= 1'b0;
            if (trn.valid) begin
                if (trn.sof) begin
                    hdr_ok    <= fmt_ok;
                    accept    <= 1'b0;
                    tag_phase <= !trn.eof;
                end else if (tag_phase) begin
                    accept    <= hdr_ok && !trn.eof &&
                                 (trn.data[44:40+`RXBUF_TAGW] == TAG_BASE[4:`RXBUF_TAGW]);
                    cur_tag   <= trn.data[40 +: `RXBUF_TAGW];
                    tag_phase <= 1'b0;
                end else if (accept) begin
                    beat.valid <= 1'b1;
                    beat.data  <= trn.data;
                    beat.tag   <= cur_tag;
                    beat.last  <= trn.eof;
                    accept     <= !trn.eof;
                end
            end
        end
    end

endmodule

// File: src/tag_table.sv
////////////////////
// per-tag ring pointers and received counts
////////////////////
`include "rxbuf_settings.svh"

module tag_table (
    input  logic                clk,
    input  logic                rst,
    input  logic                alloc_en,
    input  rxbuf_pkg::alloc_t   alloc,
    input  logic                adv_en,
    input  rxbuf_pkg::tag_t     adv_tag,
    input  rxbuf_pkg::tag_t     wr_tag,
    output rxbuf_pkg::buf_ptr_t wr_ptr,
    input  rxbuf_pkg::tag_t     cm_tag,
    output rxbuf_pkg::buf_ptr_t cm_end,
    output logic                cm_done,
    input  logic                retire
);
    import rxbuf_pkg::*;

    localparam int NTAG = 1 << `RXBUF_TAGW;

    buf_ptr_t        base_q [NTAG];
    buf_ptr_t        wptr_q [NTAG];
    logic [9:0]      req_qw [NTAG];
    logic [9:0]      rcv_qw [NTAG];
    logic [NTAG-1:0] live;          // entry allocated, not yet retired

    always_ff @(posedge clk) begin
        if (adv_en) begin
            wptr_q[adv_tag] <= wptr_q[adv_tag] + buf_ptr_t'(1);
            rcv_qw[adv_tag] <= rcv_qw[adv_tag] + 10'd1;
        end
        if (alloc_en) begin
            base_q[alloc.tag] <= alloc.base;
            wptr_q[alloc.tag] <= alloc.base;
            req_qw[alloc.tag] <= alloc.qw;
            rcv_qw[alloc.tag] <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            live <= '0;
        end else begin
            if (retire) live[cm_tag] <= 1'b0;
            if (alloc_en) live[alloc.tag] <= 1'b1;
        end
    end

    assign wr_ptr  = wptr_q[wr_tag];
    assign cm_end  = base_q[cm_tag] + req_qw[cm_tag];   // wraps with the ring
    assign cm_done = live[cm_tag] && (rcv_qw[cm_tag] == req_qw[cm_tag]);

endmodule

// File: src/cpl_writer.sv
////////////////////
// payload writes into the ring
////////////////////
`include "rxbuf_settings.svh"

module cpl_writer (
    input  logic                 clk,
    input  logic                 rst,
    input  rxbuf_pkg::cpl_beat_t beat,
    output rxbuf_pkg::tag_t      wr_tag,
    input  rxbuf_pkg::buf_ptr_t  wr_ptr,
    output logic                 adv_en,
    output rxbuf_pkg::tag_t      adv_tag,
    output logic                 wr_en,
    output rxbuf_pkg::buf_addr_t wr_addr,
    output rxbuf_pkg::qw_t       wr_data
);
    import rxbuf_pkg::*;

    logic     chain_q;  // previous cycle held a non-last beat
    buf_ptr_t ptr_q;
    buf_ptr_t cur_ptr;

    assign wr_tag = beat.tag;

    // the table lags one beat behind, so back to back beats run off ptr_q
    assign cur_ptr = chain_q ? ptr_q + buf_ptr_t'(1) : wr_ptr;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_en   <= 1'b0;
            chain_q <= 1'b0;
        end else begin
            wr_en   <= beat.valid;
            chain_q <= beat.valid && !beat.last;
            if (beat.valid) begin
                wr_addr <= cur_ptr[`RXBUF_AW-1:0];  // wrap bit dropped
                wr_data <= beat.data;
                adv_tag <= beat.tag;
                ptr_q   <= cur_ptr;
            end
        end
    end

    assign adv_en = wr_en;  // one advance per written qw

endmodule

// File: src/prod_commit.sv
////////////////////
// in-order producer pointer commit
////////////////////
module prod_commit (
    input  logic                clk,
    input  logic                rst,
    output rxbuf_pkg::tag_t     cm_tag,
    input  rxbuf_pkg::buf_ptr_t cm_end,
    input  logic                cm_done,
    output logic                retire,
    output rxbuf_pkg::buf_ptr_t committed_prod
);
    import rxbuf_pkg::*;

    commit_state_t state;
    tag_t          cur_tag;     // oldest request not yet committed

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= CM_WAIT;
            cur_tag        <= '0;
            committed_prod <= '0;
        end else begin
            case (state)
                CM_WAIT: begin
                    if (cm_done) begin
                        committed_prod <= cm_end;
                        state          <= CM_RETIRE;
                    end
                end
                CM_RETIRE: begin
                    cur_tag <= cur_tag + tag_t'(1);
                    state   <= CM_WAIT;
                end
                default: state <= CM_WAIT;
            endcase
        end
    end

    assign cm_tag = cur_tag;
    assign retire = (state == CM_RETIRE);   // clears entry, frees tag

endmodule

// File: src/rxbuf_top.sv
////////////////////
// receive buffer manager top level
////////////////////
module rxbuf_top (
    input  logic                  clk,
    input  logic                  rst,
    input  rxbuf_pkg::trn_rx_t    trn,
    input  logic [2:0]            cfg_max_rd_req_size,
    input  logic                  lbuf_req,
    input  rxbuf_pkg::host_addr_t lbuf_addr,
    input  rxbuf_pkg::qw_len_t    lbuf_qw,
    output logic                  lbuf_ack,
    output logic                  rd_req,
    output rxbuf_pkg::rd_req_t    rd,
    input  logic                  rd_ack,
    output logic                  wr_en,
    output rxbuf_pkg::buf_addr_t  wr_addr,
    output rxbuf_pkg::qw_t        wr_data,
    output rxbuf_pkg::buf_ptr_t   committed_prod,
    input  rxbuf_pkg::buf_ptr_t   committed_cons
);
    import rxbuf_pkg::*;

    logic      alloc_en;
    alloc_t    alloc;
    logic      retire;
    cpl_beat_t beat;
    logic      adv_en;
    tag_t      adv_tag;
    tag_t      wr_tag;
    buf_ptr_t  wr_ptr;
    tag_t      cm_tag;
    buf_ptr_t  cm_end;
    logic      cm_done;

    rd_req_gen u_rd_req_gen (
        .clk                 (clk),
        .rst                 (rst),
        .lbuf_req            (lbuf_req),
        .lbuf_addr           (lbuf_addr),
        .lbuf_qw             (lbuf_qw),
        .lbuf_ack            (lbuf_ack),
        .cfg_max_rd_req_size (cfg_max_rd_req_size),
        .committed_cons      (committed_cons),
        .retire              (retire),
        .rd_req              (rd_req),
        .rd                  (rd),
        .rd_ack              (rd_ack),
        .alloc_en            (alloc_en),
        .alloc               (alloc)
    );

    cpl_parser u_cpl_parser (
        .clk  (clk),
        .rst  (rst),
        .trn  (trn),
        .beat (beat)
    );

    tag_table u_tag_table (
        .clk      (clk),
        .rst      (rst),
        .alloc_en (alloc_en),
        .alloc    (alloc),
        .adv_en   (adv_en),
        .adv_tag  (adv_tag),
        .wr_tag   (wr_tag),
        .wr_ptr   (wr_ptr),
        .cm_tag   (cm_tag),
        .cm_end   (cm_end),
        .cm_done  (cm_done),
        .retire   (retire)
    );

    cpl_writer u_cpl_writer (
        .clk     (clk),
        .rst     (rst),
        .beat    (beat),
        .wr_tag  (wr_tag),
        .wr_ptr  (wr_ptr),
        .adv_en  (adv_en),
        .adv_tag (adv_tag),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data)
    );

    prod_commit u_prod_commit (
        .clk            (clk),
        .rst            (rst),
        .cm_tag         (cm_tag),
        .cm_end         (cm_end),
        .cm_done        (cm_done),
        .retire         (retire),
        .committed_prod (committed_prod)
    );

endmodule

// File: tb/rxbuf_properties.sv
////////////////////
// handshake and reset assertions, bound to the top level
////////////////////
module rxbuf_properties (
    input logic               clk,
    input logic               rst,
    input logic               lbuf_req,
    input logic               lbuf_ack,
    input logic               rd_req,
    input logic               rd_ack,
    input rxbuf_pkg::rd_req_t rd,
    input logic               wr_en
);

    // request fields hold until the host acks
    property rd_held;
        @(posedge clk) disable iff (rst)
            (rd_req && !rd_ack) |=> (!rd_req || $stable(rd));
    endproperty

    property ack_needs_req;
        @(posedge clk) disable iff (rst)
            $rose(lbuf_ack) |-> lbuf_req;
    endproperty

    property no_write_in_reset;
        @(posedge clk) rst |=> !wr_en;
    endproperty

    rd_held_a:      assert property (rd_held) else $error("rd changed while rd_req was pending");
    ack_needs_req_a: assert property (ack_needs_req) else $error("lbuf_ack rose without lbuf_req");
    no_wr_rst_a:    assert property (no_write_in_reset) else $error("wr_en high during reset");

endmodule

bind rxbuf_top rxbuf_properties u_props (
    .clk      (clk),
    .rst      (rst),
    .lbuf_req (lbuf_req),
    .lbuf_ack (lbuf_ack),
    .rd_req   (rd_req),
    .rd_ack   (rd_ack),
    .rd       (rd),
    .wr_en    (wr_en)
);

// File: tb/rxbuf_tb.sv
////////////////////
// directed testbench with host read model, ring write and commit checks
////////////////////
`include "rxbuf_settings.svh"

module rxbuf_tb;
    import rxbuf_pkg::*;

    // longest test is ~1100 payload beats plus handshakes and a wide margin
    localparam int TIMEOUT = 20000;
    localparam int MAXREQ = 128;
    localparam int GOOD = 0;
    localparam int BAD_STATUS = 1;
    localparam int BAD_FMT = 2;
    localparam int BAD_TAG = 3;
    localparam logic [4:0] TAG_BASE = `RXBUF_TAG_BASE;

    logic       clk = 1'b0;
    logic       rst;
    trn_rx_t    trn;
    logic [2:0] cfg;
    logic       lbuf_req;
    host_addr_t lbuf_addr;
    qw_len_t    lbuf_qw;
    logic       lbuf_ack;
    logic       rd_req;
    rd_req_t    rd;
    logic       rd_ack = 1'b0;
    logic       wr_en;
    buf_addr_t  wr_addr;
    qw_t        wr_data;
    buf_ptr_t   committed_prod;
    buf_ptr_t   committed_cons = '0;

    logic       cons_hold;      // freeze the consumer pointer
    buf_ptr_t   cons_value;
    int         seed;
    int         cycles;
    int         seq_count;      // requests seen in issue order
    int         commit_count;
    int         last_req_cycle;
    buf_ptr_t   ring_ptr;       // model of the issued pointer
    buf_ptr_t   prev_prod;
    host_addr_t req_addr [MAXREQ];
    int         req_qw   [MAXREQ];
    tag_t       req_tag  [MAXREQ];
    buf_ptr_t   req_base [MAXREQ];
    logic       sent     [MAXREQ];
    int         pending  [$];   // acked, not yet answered
    buf_addr_t  exp_addr [$];
    qw_t        exp_data [$];

    rxbuf_top DUT (
        .clk                 (clk),
        .rst                 (rst),
        .trn                 (trn),
        .cfg_max_rd_req_size (cfg),
        .lbuf_req            (lbuf_req),
        .lbuf_addr           (lbuf_addr),
        .lbuf_qw             (lbuf_qw),
        .lbuf_ack            (lbuf_ack),
        .rd_req              (rd_req),
        .rd                  (rd),
        .rd_ack              (rd_ack),
        .wr_en               (wr_en),
        .wr_addr             (wr_addr),
        .wr_data             (wr_data),
        .committed_prod      (committed_prod),
        .committed_cons      (committed_cons)
    );

    always #10 clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    function automatic int chunk_limit(input logic [2:0] c);
        case (c)
            3'd0:    return 16;
            3'd1:    return 32;
            3'd2:    return 64;
            default: return 128;
        endcase
    endfunction

    ////////////////////
    // host side monitors
    ////////////////////
    task automatic watch_host();
        logic [`RXBUF_AW+1:0] need;
        if (rd_req && !rd_ack) begin
            assert (seq_count < MAXREQ) else fail_run("too many read requests");
            assert (seq_count - commit_count < 4)
                else fail_run("read request issued with 4 tags outstanding");
            need = {1'b0, ring_ptr - committed_cons} + 11'(rd.qw);
            assert (need <= 11'd512) else fail_run("read request issued past free ring space");
            assert (rd.tag == tag_t'(seq_count))
                else fail_run($sformatf("mismatch at %0t: rd.tag got %0d expected %0d",
                                        $time, rd.tag, tag_t'(seq_count)));
            req_addr[seq_count] = rd.addr;
            req_qw[seq_count]   = int'(rd.qw);
            req_tag[seq_count]  = rd.tag;
            req_base[seq_count] = ring_ptr;
            sent[seq_count]     = 1'b0;
            ring_ptr            = ring_ptr + buf_ptr_t'(rd.qw);
            pending.push_back(seq_count);
            seq_count      = seq_count + 1;
            last_req_cycle = cycles;
            rd_ack <= 1'b1;
        end else if (!rd_req && rd_ack) begin
            rd_ack <= 1'b0;
        end
    endtask

    task automatic watch_commit();
        buf_ptr_t exp_end;
        if (committed_prod != prev_prod) begin
            assert (commit_count < seq_count)
                else fail_run("committed_prod moved with no request outstanding");
            exp_end = req_base[commit_count] + buf_ptr_t'(req_qw[commit_count]);
            assert (sent[commit_count]) else fail_run("commit ahead of an incomplete request");
            assert (committed_prod == exp_end)
                else fail_run($sformatf("mismatch at %0t: committed_prod got %h expected %h",
                                        $time, committed_prod, exp_end));
            commit_count = commit_count + 1;
            prev_prod    = committed_prod;
        end
    endtask

    task automatic watch_writes();
        buf_addr_t ea;
        qw_t       ed;
        if (wr_en) begin
            assert (exp_addr.size() > 0) else fail_run("ring write with no payload pending");
            ea = exp_addr.pop_front();
            ed = exp_data.pop_front();
            assert (wr_addr == ea)
                else fail_run($sformatf("mismatch at %0t: wr_addr got %h expected %h",
                                        $time, wr_addr, ea));
            assert (wr_data == ed)
                else fail_run($sformatf("mismatch at %0t: wr_data got %h expected %h",
                                        $time, wr_data, ed));
        end
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout after %0d cycles, %0d requests seen", cycles, seq_count);
            $display("Regression failed");
            $fatal(1);
        end else begin
            committed_cons <= cons_hold ? cons_value : committed_prod;  // consumer drains at once
            if (!rst) begin
                watch_host();
                watch_commit();
                watch_writes();
            end
        end
    end

    ////////////////////
    // stimulus helpers
    ////////////////////
    task automatic drive_beat(input qw_t d, input logic s, input logic e);
        trn_rx_t t;
        t.data  = d;
        t.sof   = s;
        t.eof   = e;
        t.valid = 1'b1;
        @(posedge clk);
        trn <= t;
    endtask

    task automatic send_cpl(input host_addr_t addr, input int qw, input tag_t tag,
                            input buf_ptr_t base, input int kind);
        qw_t h0;
        qw_t h1;
        int  i;
        h0 = '0;
        h0[62:56] = (kind == BAD_FMT) ? 7'b0000000 : `RXBUF_CPL_FMT_TYPE;
        h0[15:13] = (kind == BAD_STATUS) ? 3'b100 : `RXBUF_CPL_SC;
        h0[41:32] = 10'(2 * qw);    // dword count
        h1 = '0;
        h1[44:40] = {TAG_BASE[4:`RXBUF_TAGW], tag};
        if (kind == BAD_TAG) h1[44] = ~h1[44];
        drive_beat(h0, 1'b1, 1'b0);
        drive_beat(h1, 1'b0, 1'b0);
        for (i = 0; i < qw; i++) begin
            if (kind == GOOD) begin
                exp_addr.push_back(buf_addr_t'(base + buf_ptr_t'(i)));
                exp_data.push_back(addr + host_addr_t'(8 * i));
            end
            drive_beat(addr + host_addr_t'(8 * i), 1'b0, i == qw - 1);
        end
        @(posedge clk);
        trn <= '0;
    endtask

    task automatic run_desc(input host_addr_t addr, input int qw, input logic [2:0] c);
        int first;
        int nreq;
        first = seq_count;
        nreq  = (qw + chunk_limit(c) - 1) / chunk_limit(c);
        @(posedge clk);
        cfg       <= c;
        lbuf_addr <= addr;
        lbuf_qw   <= qw_len_t'(qw);
        lbuf_req  <= 1'b1;
        while (!lbuf_ack) @(posedge clk);
        assert (seq_count == first + nreq)
            else fail_run($sformatf("mismatch at %0t: request count got %0d expected %0d",
                                    $time, seq_count - first, nreq));
        lbuf_req <= 1'b0;
        while (lbuf_ack) @(posedge clk);
    endtask

    // answers acked requests in random order once the request side goes quiet
    task automatic answer_all(input int target);
        int idx;
        int s;
        while (commit_count < target) begin
            @(posedge clk);
            if (pending.size() > 0 && cycles - last_req_cycle > 12) begin
                idx = int'($unsigned($random(seed)) % pending.size());
                s   = pending[idx];
                pending.delete(idx);
                send_cpl(req_addr[s], req_qw[s], req_tag[s], req_base[s], GOOD);
                sent[s] = 1'b1;
            end
        end
    endtask

    task automatic release_space(input int first);
        while (commit_count < first + 4) @(posedge clk);
        repeat (40) @(posedge clk);
        assert (seq_count == first + 4) else fail_run("read request issued while the ring was full");
        assert (committed_prod == cons_value + buf_ptr_t'(512))
            else fail_run($sformatf("mismatch at %0t: committed_prod got %h expected %h",
                                    $time, committed_prod, cons_value + buf_ptr_t'(512)));
        cons_value = committed_prod;
    endtask

    ////////////////////
    // tests
    ////////////////////
    task automatic check_reset();
        assert (!lbuf_ack) else fail_run("lbuf_ack high after reset");
        assert (!rd_req) else fail_run("rd_req high after reset");
        assert (!wr_en) else fail_run("wr_en high after reset");
        assert (committed_prod == '0)
            else fail_run($sformatf("mismatch at %0t: committed_prod got %h expected 0",
                                    $time, committed_prod));
    endtask

    task automatic flow_control();
        int first;
        first      = seq_count;
        cons_value = committed_prod;
        cons_hold  = 1'b1;
        fork
            run_desc(64'h0000_0001_0000_0000, 600, 3'd3);
            answer_all(first + 5);
            release_space(first);
        join
        cons_hold = 1'b0;
    endtask

    task automatic chunking();
        int         first;
        int         i;
        int         exp_qw;
        host_addr_t exp_a;
        first = seq_count;
        fork
            run_desc(64'h0000_0000_0010_0000, 100, 3'd0);
            answer_all(first + 7);
        join
        for (i = 0; i < 7; i++) begin
            exp_qw = (i < 6) ? 16 : 4;
            exp_a  = 64'h0000_0000_0010_0000 + host_addr_t'(128 * i);
            assert (req_qw[first + i] == exp_qw)
                else fail_run($sformatf("mismatch at %0t: rd.qw got %0d expected %0d",
                                        $time, req_qw[first + i], exp_qw));
            assert (req_addr[first + i] == exp_a)
                else fail_run($sformatf("mismatch at %0t: rd.addr got %h expected %h",
                                        $time, req_addr[first + i], exp_a));
        end
    endtask

    task automatic placement_and_order();
        int       first;
        buf_ptr_t exp_prod;
        first    = seq_count;
        exp_prod = committed_prod + buf_ptr_t'(1100);   // modulo 1024
        fork
            run_desc(64'h0000_0002_0000_0400, 1100, 3'd1);
            answer_all(first + 35);
        join
        assert (committed_prod == exp_prod)
            else fail_run($sformatf("mismatch at %0t: committed_prod got %h expected %h",
                                    $time, committed_prod, exp_prod));
    endtask

    task automatic filtering();
        buf_ptr_t start;
        int       first;
        start = committed_prod;
        first = seq_count;
        // a live request, so an accepted bad completion would also commit
        run_desc(64'h0000_0003_0000_0000, 4, 3'd0);
        send_cpl(req_addr[first], req_qw[first], req_tag[first], req_base[first], BAD_STATUS);
        send_cpl(req_addr[first], req_qw[first], req_tag[first], req_base[first], BAD_FMT);
        send_cpl(req_addr[first], req_qw[first], req_tag[first], req_base[first], BAD_TAG);
        repeat (20) @(posedge clk);
        assert (committed_prod == start)
            else fail_run($sformatf("mismatch at %0t: committed_prod got %h expected %h",
                                    $time, committed_prod, start));
        answer_all(first + 1);
    endtask

    initial begin
        seed           = 32'h68f7_b691;
        cycles         = 0;
        seq_count      = 0;
        commit_count   = 0;
        last_req_cycle = 0;
        ring_ptr       = '0;
        prev_prod      = '0;
        cons_hold      = 1'b0;
        cons_value     = '0;
        rst            = 1'b1;
        trn            = '0;
        cfg            = 3'd0;
        lbuf_req       = 1'b0;
        lbuf_addr      = '0;
        lbuf_qw        = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_reset();
        flow_control();
        chunking();
        placement_and_order();
        filtering();
        assert (exp_addr.size() == 0 && pending.size() == 0 && commit_count == seq_count)
            else fail_run("payload or requests left over at the end");
        $display("Regression passed");
        $finish;
    end

endmodule

// File: rxbuf_top.f
+incdir+src
src/rxbuf_pkg.sv
src/rd_req_gen.sv
src/cpl_parser.sv
src/tag_table.sv
src/cpl_writer.sv
src/prod_commit.sv
src/rxbuf_top.sv
tb/rxbuf_properties.sv
tb/rxbuf_tb.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the receive buffer testbench with Verilator
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert --top-module rxbuf_tb -f rxbuf_top.f -o rxbuf_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/rxbuf_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Regression failed" "$LOG"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0
